//--- design/cpu_pkg.sv
package cpu_pkg;

   //////////////////////////////////////////////////////////////////////
   // ISA field widths
   //////////////////////////////////////////////////////////////////////
   localparam int WORD_W     = 16;
   localparam int REG_ADDR_W = 2;
   localparam int OPCODE_W   = 4;
   localparam int FUNC_W     = 6;
   localparam int IMM_W      = 8;
   localparam int TARGET_W   = 12;

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // Opcodes, bits 15..12
   typedef enum logic [OPCODE_W-1:0] {
      OP_BNE   = 4'd0,
      OP_BEQ   = 4'd1,
      OP_ADI   = 4'd4,
      OP_LHI   = 4'd6,
      OP_JMP   = 4'd9,
      OP_RTYPE = 4'd15
   } opcode_t;

   // R-type function codes, bits 5..0
   typedef enum logic [FUNC_W-1:0] {
      FN_ADD = 6'd0,
      FN_SUB = 6'd1,
      FN_AND = 6'd2,
      FN_ORR = 6'd3,
      FN_WWD = 6'd28,
      FN_HLT = 6'd29
   } func_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_PASS_B,
      ALU_EQ,
      ALU_NE
   } alu_op_t;

   //////////////////////////////////////////////////////////////////////
   // Stage payloads
   //////////////////////////////////////////////////////////////////////
   typedef struct packed {
      reg_addr_t rs;
      reg_addr_t rt;
      reg_addr_t write_reg;
      word_t     a;
      word_t     b;
      // Sign-extended immediate
      word_t     imm;
      word_t     npc;
      alu_op_t   alu_op;
      logic      use_imm;
      logic      reg_write;
      logic      is_branch;
      logic      out_write;
      logic      halt;
   } id_ex_t;

   typedef struct packed {
      reg_addr_t write_reg;
      word_t     result;
      logic      reg_write;
      logic      out_write;
      logic      halt;
   } ex_wb_t;

   typedef enum logic [1:0] {
      ST_RUN,
      ST_DRAIN,
      ST_HALTED
   } ctrl_state_t;

endpackage

//--- design/wb_if.sv
`timescale 1ns/1ps

interface wb_if
   import cpu_pkg::*;
();
   // Instruction currently in WB
   logic      w_valid;
   logic      w_reg_write;
   reg_addr_t w_reg;
   word_t     w_data;
   logic      w_halt;

   // EX/WB register side
   modport source (
      output w_valid, w_reg_write, w_reg, w_data, w_halt
   );

   // Register file, forwarding, counter and control
   modport sink (
      input w_valid, w_reg_write, w_reg, w_data, w_halt
   );
endinterface

//--- design/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
   parameter type T = logic
) (
   input  logic clk,
   input  logic reset_n,
   input  logic i_bubble,
   input  T     i_d,
   input  logic i_valid,
   output T     o_q,
   output logic o_valid
);

   // Bubble loads an all-zero payload
   // so every downstream control flag reads inactive
   always_ff @(posedge clk) begin
      if (!reset_n || i_bubble) begin
         o_q     <= '0;
         o_valid <= 1'b0;
      end else begin
         o_q     <= i_d;
         o_valid <= i_valid;
      end
   end

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file
   import cpu_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   input  reg_addr_t i_raddr1,
   input  reg_addr_t i_raddr2,
   output word_t     o_rdata1,
   output word_t     o_rdata2,
   wb_if.sink        wb
);

   word_t regs [4];
   logic  wr_en;

   // Write request from the instruction in WB
   assign wr_en = wb.w_valid && wb.w_reg_write;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < 4; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb.w_reg] <= wb.w_data;
      end
   end

   // Write-through, ID sees the value WB writes this cycle
   assign o_rdata1 = (wr_en && wb.w_reg == i_raddr1) ? wb.w_data : regs[i_raddr1];
   assign o_rdata2 = (wr_en && wb.w_reg == i_raddr2) ? wb.w_data : regs[i_raddr2];

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
   import cpu_pkg::*;
(
   input  logic  clk,
   input  logic  reset_n,
   input  logic  i_hold,
   input  logic  i_flush_if,
   input  logic  i_jump,
   input  word_t i_jump_target,
   input  logic  i_redirect,
   input  word_t i_redirect_pc,
   input  word_t i_inst,
   output word_t o_pc,
   output word_t o_ir,
   output logic  o_ir_valid,
   output word_t o_npc
);

   word_t pc;
   word_t pc_plus1;
   word_t next_pc;

   assign pc_plus1 = pc + word_t'(1);

   // Branch in EX is older than a jump in ID, so it wins
   always_comb begin
      if (i_redirect) begin
         next_pc = i_redirect_pc;
      end else if (i_jump) begin
         next_pc = i_jump_target;
      end else begin
         next_pc = pc_plus1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pc <= '0;
      end else if (!i_hold) begin
         pc <= next_pc;
      end
   end

   // Flush beats hold, a halted fetch leaves an empty IF/ID
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_ir_valid <= 1'b0;
      end else if (i_flush_if) begin
         o_ir_valid <= 1'b0;
      end else if (!i_hold) begin
         o_ir_valid <= 1'b1;
      end
   end

   // IF/ID payload
   always_ff @(posedge clk) begin
      if (!i_hold) begin
         o_ir  <= i_inst;
         o_npc <= pc_plus1;
      end
   end

   assign o_pc = pc;

endmodule

//--- design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit
   import cpu_pkg::*;
(
   input  word_t     i_ir,
   input  logic      i_ir_valid,
   input  word_t     i_npc,
   input  word_t     i_rdata1,
   input  word_t     i_rdata2,
   output reg_addr_t o_raddr1,
   output reg_addr_t o_raddr2,
   output id_ex_t    o_payload,
   output logic      o_jump,
   output word_t     o_jump_target,
   output logic      o_halt_seen
);

   opcode_t               opcode;
   func_t                 func;
   reg_addr_t             rs;
   reg_addr_t             rt;
   reg_addr_t             rd;
   logic [IMM_W-1:0]      imm;
   logic [TARGET_W-1:0]   target;
   alu_op_t               alu_op;
   logic                  use_imm;
   logic                  reg_write;
   logic                  is_branch;
   logic                  out_write;
   logic                  halt;
   logic                  dst_rd;

   //////////////////////////////////////////////////////////////////////
   // Field split
   //////////////////////////////////////////////////////////////////////
   assign opcode = opcode_t'(i_ir[15:12]);
   assign rs     = i_ir[11:10];
   assign rt     = i_ir[9:8];
   assign rd     = i_ir[7:6];
   assign imm    = i_ir[7:0];
   assign target = i_ir[11:0];
   assign func   = func_t'(i_ir[5:0]);

   assign o_raddr1 = rs;
   assign o_raddr2 = rt;

   //////////////////////////////////////////////////////////////////////
   // Control generation
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      alu_op    = ALU_ADD;
      use_imm   = 1'b0;
      reg_write = 1'b0;
      is_branch = 1'b0;
      out_write = 1'b0;
      halt      = 1'b0;
      dst_rd    = 1'b0;
      case (opcode)
         OP_RTYPE: begin
            // R-type writes rd
            dst_rd = 1'b1;
            case (func)
               FN_ADD: begin
                  alu_op    = ALU_ADD;
                  reg_write = 1'b1;
               end
               FN_SUB: begin
                  alu_op    = ALU_SUB;
                  reg_write = 1'b1;
               end
               FN_AND: begin
                  alu_op    = ALU_AND;
                  reg_write = 1'b1;
               end
               FN_ORR: begin
                  alu_op    = ALU_OR;
                  reg_write = 1'b1;
               end
               FN_WWD: out_write = 1'b1;
               FN_HLT: halt = 1'b1;
               default: ;
            endcase
         end
         OP_ADI: begin
            use_imm   = 1'b1;
            reg_write = 1'b1;
         end
         OP_LHI: begin
            alu_op    = ALU_PASS_B;
            use_imm   = 1'b1;
            reg_write = 1'b1;
         end
         OP_BNE: begin
            alu_op    = ALU_NE;
            is_branch = 1'b1;
         end
         OP_BEQ: begin
            alu_op    = ALU_EQ;
            is_branch = 1'b1;
         end
         // JMP resolves here, nothing goes down the pipe
         default: ;
      endcase
   end

   // Jump keeps the upper PC nibble
   assign o_jump        = i_ir_valid && (opcode == OP_JMP);
   assign o_jump_target = {i_npc[WORD_W-1:TARGET_W], target};
   assign o_halt_seen   = i_ir_valid && halt;

   //////////////////////////////////////////////////////////////////////
   // ID/EX payload
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      o_payload           = '0;
      o_payload.rs        = rs;
      o_payload.rt        = rt;
      o_payload.write_reg = dst_rd ? rd : rt;
      o_payload.a         = i_rdata1;
      o_payload.b         = i_rdata2;
      o_payload.imm       = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
      o_payload.npc       = i_npc;
      o_payload.alu_op    = alu_op;
      o_payload.use_imm   = use_imm;
      // Flags only for a live instruction
      o_payload.reg_write = reg_write && i_ir_valid;
      o_payload.is_branch = is_branch && i_ir_valid;
      o_payload.out_write = out_write && i_ir_valid;
      o_payload.halt      = halt && i_ir_valid;
   end

endmodule

//--- design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
   import cpu_pkg::*;
(
   input  logic   clk,
   input  logic   reset_n,
   input  id_ex_t i_payload,
   input  logic   i_valid,
   wb_if.sink     wb,
   output ex_wb_t o_result,
   output logic   o_redirect,
   output word_t  o_redirect_pc,
   output word_t  o_output_port
);

   logic  wb_writes;
   word_t fwd_a;
   word_t fwd_b;
   word_t lhi_imm;
   word_t op_b;
   word_t alu_out;

   //////////////////////////////////////////////////////////////////////
   // Forwarding from WB
   //////////////////////////////////////////////////////////////////////
   assign wb_writes = wb.w_valid && wb.w_reg_write;
   assign fwd_a = (wb_writes && wb.w_reg == i_payload.rs) ? wb.w_data : i_payload.a;
   assign fwd_b = (wb_writes && wb.w_reg == i_payload.rt) ? wb.w_data : i_payload.b;

   // LHI places the low immediate byte on top
   assign lhi_imm = {i_payload.imm[IMM_W-1:0], {IMM_W{1'b0}}};

   always_comb begin
      if (!i_payload.use_imm) begin
         op_b = fwd_b;
      end else if (i_payload.alu_op == ALU_PASS_B) begin
         op_b = lhi_imm;
      end else begin
         op_b = i_payload.imm;
      end
   end

   // ALU
   always_comb begin
      case (i_payload.alu_op)
         ALU_ADD:    alu_out = fwd_a + op_b;
         ALU_SUB:    alu_out = fwd_a - op_b;
         ALU_AND:    alu_out = fwd_a & op_b;
         ALU_OR:     alu_out = fwd_a | op_b;
         ALU_PASS_B: alu_out = op_b;
         ALU_EQ:     alu_out = word_t'(fwd_a == op_b);
         ALU_NE:     alu_out = word_t'(fwd_a != op_b);
         default:    alu_out = '0;
      endcase
   end

   // Branch resolves here, taken means mispredicted
   assign o_redirect    = i_valid && i_payload.is_branch && alu_out[0];
   assign o_redirect_pc = i_payload.npc + i_payload.imm;

   //////////////////////////////////////////////////////////////////////
   // EX/WB payload
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      o_result.write_reg = i_payload.write_reg;
      // WWD carries rs out
      o_result.result    = i_payload.out_write ? fwd_a : alu_out;
      o_result.reg_write = i_valid && i_payload.reg_write;
      o_result.out_write = i_valid && i_payload.out_write;
      o_result.halt      = i_valid && i_payload.halt;
   end

   // Output port, updated as WWD enters EX/WB
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_output_port <= '0;
      end else if (o_result.out_write) begin
         o_output_port <= o_result.result;
      end
   end

endmodule

//--- design/pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control
   import cpu_pkg::*;
(
   input  logic clk,
   input  logic reset_n,
   input  logic i_halt_seen,
   input  logic i_jump,
   input  logic i_redirect,
   wb_if.sink   wb,
   output logic o_hold,
   output logic o_flush_if,
   output logic o_flush_id,
   output logic o_is_halted
);

   ctrl_state_t state;
   ctrl_state_t state_next;
   logic        halt_retired;
   logic        halt_enter;

   assign halt_retired = wb.w_valid && wb.w_halt;

   // A HLT on a mispredicted path must not stop the core
   assign halt_enter = i_halt_seen && !i_redirect;

   always_comb begin
      state_next = state;
      o_hold     = 1'b1;
      o_flush_if = 1'b1;
      o_flush_id = 1'b1;
      case (state)
         ST_RUN: begin
            o_hold     = halt_enter;
            // Redirect kills IF and ID, jump kills IF
            o_flush_if = i_redirect || i_jump || i_halt_seen;
            o_flush_id = i_redirect;
            if (halt_enter) begin
               state_next = ST_DRAIN;
            end
         end
         ST_DRAIN: begin
            // Wait for the HLT to reach WB
            if (halt_retired) begin
               state_next = ST_HALTED;
            end
         end
         // Final until reset
         default: state_next = ST_HALTED;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= ST_RUN;
      end else begin
         state <= state_next;
      end
   end

   assign o_is_halted = (state == ST_HALTED);

endmodule

//--- design/retire_counter.sv
`timescale 1ns/1ps

module retire_counter
   import cpu_pkg::*;
(
   input  logic  clk,
   input  logic  reset_n,
   wb_if.sink    wb,
   output word_t o_num_inst
);

   logic halt_done;

   // Bubbles are invalid and never counted
   // HLT itself counts, nothing after it
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_num_inst <= '0;
         halt_done  <= 1'b0;
      end else if (wb.w_valid && !halt_done) begin
         o_num_inst <= o_num_inst + word_t'(1);
         if (wb.w_halt) begin
            halt_done <= 1'b1;
         end
      end
   end

endmodule

//--- design/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
   import cpu_pkg::*;
(
   input  logic  clk,
   input  logic  reset_n,
   output word_t o_i_address,
   input  word_t i_i_data,
   output word_t o_output_port,
   output logic  o_is_halted,
   output word_t o_num_inst
);

   word_t     ir;
   logic      ir_valid;
   word_t     npc;
   reg_addr_t raddr1;
   reg_addr_t raddr2;
   word_t     rdata1;
   word_t     rdata2;
   id_ex_t    id_payload;
   id_ex_t    ex_payload;
   logic      ex_valid;
   ex_wb_t    ex_result;
   ex_wb_t    wb_payload;
   logic      wb_valid;
   logic      jump;
   word_t     jump_target;
   logic      redirect;
   word_t     redirect_pc;
   logic      halt_seen;
   logic      hold;
   logic      flush_if;
   logic      flush_id;

   wb_if wb_bus ();

   // WB view of the EX/WB register
   assign wb_bus.w_valid     = wb_valid;
   assign wb_bus.w_reg_write = wb_payload.reg_write;
   assign wb_bus.w_reg       = wb_payload.write_reg;
   assign wb_bus.w_data      = wb_payload.result;
   assign wb_bus.w_halt      = wb_payload.halt;

   //////////////////////////////////////////////////////////////////////
   // IF and ID
   //////////////////////////////////////////////////////////////////////
   fetch_unit u_fetch (
      .clk           (clk),
      .reset_n       (reset_n),
      .i_hold        (hold),
      .i_flush_if    (flush_if),
      .i_jump        (jump),
      .i_jump_target (jump_target),
      .i_redirect    (redirect),
      .i_redirect_pc (redirect_pc),
      .i_inst        (i_i_data),
      .o_pc          (o_i_address),
      .o_ir          (ir),
      .o_ir_valid    (ir_valid),
      .o_npc         (npc)
   );

   decode_unit u_decode (
      .i_ir          (ir),
      .i_ir_valid    (ir_valid),
      .i_npc         (npc),
      .i_rdata1      (rdata1),
      .i_rdata2      (rdata2),
      .o_raddr1      (raddr1),
      .o_raddr2      (raddr2),
      .o_payload     (id_payload),
      .o_jump        (jump),
      .o_jump_target (jump_target),
      .o_halt_seen   (halt_seen)
   );

   register_file u_rf (
      .clk      (clk),
      .reset_n  (reset_n),
      .i_raddr1 (raddr1),
      .i_raddr2 (raddr2),
      .o_rdata1 (rdata1),
      .o_rdata2 (rdata2),
      .wb       (wb_bus.sink)
   );

   stage_reg #(.T(id_ex_t)) u_id_ex (
      .clk      (clk),
      .reset_n  (reset_n),
      .i_bubble (flush_id),
      .i_d      (id_payload),
      .i_valid  (ir_valid),
      .o_q      (ex_payload),
      .o_valid  (ex_valid)
   );

   //////////////////////////////////////////////////////////////////////
   // EX and WB
   //////////////////////////////////////////////////////////////////////
   execute_unit u_execute (
      .clk           (clk),
      .reset_n       (reset_n),
      .i_payload     (ex_payload),
      .i_valid       (ex_valid),
      .wb            (wb_bus.sink),
      .o_result      (ex_result),
      .o_redirect    (redirect),
      .o_redirect_pc (redirect_pc),
      .o_output_port (o_output_port)
   );

   // Nothing enters WB once halted
   stage_reg #(.T(ex_wb_t)) u_ex_wb (
      .clk      (clk),
      .reset_n  (reset_n),
      .i_bubble (o_is_halted),
      .i_d      (ex_result),
      .i_valid  (ex_valid),
      .o_q      (wb_payload),
      .o_valid  (wb_valid)
   );

   pipeline_control u_ctrl (
      .clk         (clk),
      .reset_n     (reset_n),
      .i_halt_seen (halt_seen),
      .i_jump      (jump),
      .i_redirect  (redirect),
      .wb          (wb_bus.sink),
      .o_hold      (hold),
      .o_flush_if  (flush_if),
      .o_flush_id  (flush_id),
      .o_is_halted (o_is_halted)
   );

   retire_counter u_retire (
      .clk        (clk),
      .reset_n    (reset_n),
      .wb         (wb_bus.sink),
      .o_num_inst (o_num_inst)
   );

endmodule

//--- sim/cpu_props.sv
`timescale 1ns/1ps

module cpu_props
   import cpu_pkg::*;
(
   input logic        clk,
   input logic        reset_n,
   input ctrl_state_t i_state,
   input logic        i_hold,
   input logic        i_flush_id,
   input logic        i_redirect
);

   //////////////////////////////////////////////////////////////////////
   // Control FSM properties
   //////////////////////////////////////////////////////////////////////

   // Only reset leaves HALTED
   property halted_is_final;
      @(posedge clk) disable iff (!reset_n)
         (i_state == ST_HALTED) |=> (i_state == ST_HALTED);
   endproperty

   // Fetch frozen in DRAIN and HALTED
   property fetch_held_unless_run;
      @(posedge clk) disable iff (!reset_n)
         (i_state != ST_RUN) |-> i_hold;
   endproperty

   // Mispredicted branch bubbles ID/EX
   property redirect_bubbles_id;
      @(posedge clk) disable iff (!reset_n)
         i_redirect |-> i_flush_id;
   endproperty

   halted_stays: assert property (halted_is_final)
      else $error("pipeline_control left HALTED without a reset");

   hold_outside_run: assert property (fetch_held_unless_run)
      else $error("fetch not held while the control FSM is not in RUN");

   flush_on_redirect: assert property (redirect_bubbles_id)
      else $error("taken branch did not flush the ID/EX register");

endmodule

bind pipeline_control cpu_props u_props (
   .clk        (clk),
   .reset_n    (reset_n),
   .i_state    (state),
   .i_hold     (o_hold),
   .i_flush_id (o_flush_id),
   .i_redirect (i_redirect)
);

//--- sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
   import cpu_pkg::*;
();

   localparam int N_TESTS         = 5;
   localparam int PROG_MAX        = 12;
   localparam int MEM_WORDS       = 64;
   localparam int RESET_CYCLES    = 3;
   localparam int HALT_HOLD       = 10;
   localparam int CYCLES_PER_TEST = 60;
   localparam int CYCLE_LIMIT     = N_TESTS * CYCLES_PER_TEST;

   logic  clk;
   logic  reset_n;
   word_t i_address;
   word_t i_data;
   word_t output_port;
   logic  is_halted;
   word_t num_inst;

   // Instruction memory, answers in the same cycle
   word_t imem [MEM_WORDS];

   // Program table with hand-computed results
   string test_name [N_TESTS];
   word_t prog      [N_TESTS][PROG_MAX];
   word_t exp_out   [N_TESTS];
   word_t exp_num   [N_TESTS];
   // Fetch stops one past the HLT
   word_t exp_pc    [N_TESTS];

   string cur_name;
   int    cycle_count = 0;
   int    error_count = 0;
   int    test_errors = 0;
   int    pass_count  = 0;

   cpu_top uut (
      .clk           (clk),
      .reset_n       (reset_n),
      .o_i_address   (i_address),
      .i_i_data      (i_data),
      .o_output_port (output_port),
      .o_is_halted   (is_halted),
      .o_num_inst    (num_inst)
   );

   assign i_data = imem[i_address[5:0]];

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Watchdog over the whole run
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout in test %s: the core did not halt within %0d cycles",
                  cur_name, CYCLE_LIMIT);
         $display("Finished with errors");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Instruction encoders
   //////////////////////////////////////////////////////////////////////
   function automatic word_t rtype_inst(func_t fn, reg_addr_t rs, reg_addr_t rt,
                                        reg_addr_t rd);
      return {OP_RTYPE, rs, rt, rd, fn};
   endfunction

   function automatic word_t imm_inst(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                      logic [7:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // Also used as the fill, a jump to its own address
   function automatic word_t jump_inst(logic [11:0] target);
      return {OP_JMP, target};
   endfunction

   task automatic check_word(input string what, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("** Error: %s: %s expected %h, actual %h",
                  cur_name, what, expected, actual);
         test_errors++;
         error_count++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Programs
   //////////////////////////////////////////////////////////////////////
   task automatic fill_table();
      int t;
      int a;
      // Unused slots hold HLT
      for (t = 0; t < N_TESTS; t++) begin
         for (a = 0; a < PROG_MAX; a++) begin
            prog[t][a] = rtype_inst(FN_HLT, 2'd0, 2'd0, 2'd0);
         end
      end

      // r1=5, r2=3, r3=8, r0=fffd, r1=8, r2=b
      test_name[0] = "dependent_arith";
      prog[0][0]   = imm_inst(OP_ADI, 2'd0, 2'd1, 8'd5);
      prog[0][1]   = imm_inst(OP_ADI, 2'd1, 2'd2, 8'hfe);
      prog[0][2]   = rtype_inst(FN_ADD, 2'd1, 2'd2, 2'd3);
      prog[0][3]   = rtype_inst(FN_SUB, 2'd1, 2'd3, 2'd0);
      prog[0][4]   = rtype_inst(FN_AND, 2'd0, 2'd3, 2'd1);
      prog[0][5]   = rtype_inst(FN_ORR, 2'd1, 2'd2, 2'd2);
      prog[0][6]   = rtype_inst(FN_WWD, 2'd2, 2'd0, 2'd0);
      exp_out[0]   = 16'h000b;
      exp_num[0]   = 16'd8;
      exp_pc[0]    = 16'd8;

      // Upper byte a5 joined with 3c
      test_name[1] = "lhi_orr";
      prog[1][0]   = imm_inst(OP_LHI, 2'd0, 2'd1, 8'ha5);
      prog[1][1]   = imm_inst(OP_ADI, 2'd0, 2'd2, 8'h3c);
      prog[1][2]   = rtype_inst(FN_ORR, 2'd1, 2'd2, 2'd3);
      prog[1][3]   = rtype_inst(FN_WWD, 2'd3, 2'd0, 2'd0);
      exp_out[1]   = 16'ha53c;
      exp_num[1]   = 16'd5;
      exp_pc[1]    = 16'd5;

      // BNE taken to 4 skips two ADIs, BEQ falls through to 5
      test_name[2] = "branch_paths";
      prog[2][0]   = imm_inst(OP_ADI, 2'd0, 2'd1, 8'd1);
      prog[2][1]   = imm_inst(OP_BNE, 2'd1, 2'd0, 8'd2);
      prog[2][2]   = imm_inst(OP_ADI, 2'd0, 2'd2, 8'h11);
      prog[2][3]   = imm_inst(OP_ADI, 2'd0, 2'd3, 8'h22);
      prog[2][4]   = imm_inst(OP_BEQ, 2'd1, 2'd0, 8'd1);
      prog[2][5]   = imm_inst(OP_ADI, 2'd1, 2'd1, 8'd6);
      prog[2][6]   = rtype_inst(FN_ADD, 2'd1, 2'd2, 2'd0);
      prog[2][7]   = rtype_inst(FN_ADD, 2'd0, 2'd3, 2'd0);
      prog[2][8]   = rtype_inst(FN_WWD, 2'd0, 2'd0, 2'd0);
      exp_out[2]   = 16'h0007;
      exp_num[2]   = 16'd8;
      exp_pc[2]    = 16'd10;

      // Skipped WWD r0 would clear the port
      test_name[3] = "jump_skip";
      prog[3][0]   = imm_inst(OP_ADI, 2'd0, 2'd1, 8'h12);
      prog[3][1]   = rtype_inst(FN_WWD, 2'd1, 2'd0, 2'd0);
      prog[3][2]   = jump_inst(12'd4);
      prog[3][3]   = rtype_inst(FN_WWD, 2'd0, 2'd0, 2'd0);
      exp_out[3]   = 16'h0012;
      exp_num[3]   = 16'd4;
      exp_pc[3]    = 16'd5;

      // HLT on the wrong path of a taken BNE
      test_name[4] = "halt_behind_branch";
      prog[4][0]   = imm_inst(OP_ADI, 2'd0, 2'd1, 8'hff);
      prog[4][1]   = imm_inst(OP_BNE, 2'd1, 2'd0, 8'd1);
      prog[4][2]   = rtype_inst(FN_HLT, 2'd0, 2'd0, 2'd0);
      prog[4][3]   = rtype_inst(FN_ADD, 2'd1, 2'd1, 2'd2);
      prog[4][4]   = rtype_inst(FN_WWD, 2'd2, 2'd0, 2'd0);
      prog[4][5]   = rtype_inst(FN_HLT, 2'd0, 2'd0, 2'd0);
      prog[4][6]   = rtype_inst(FN_WWD, 2'd1, 2'd0, 2'd0);
      exp_out[4]   = 16'hfffe;
      exp_num[4]   = 16'd5;
      exp_pc[4]    = 16'd6;
   endtask

   //////////////////////////////////////////////////////////////////////
   // One table row
   //////////////////////////////////////////////////////////////////////
   task automatic run_test(input int t);
      int    a;
      word_t held_out;
      word_t held_num;
      cur_name    = test_name[t];
      test_errors = 0;

      // Load the program while reset is applied
      @(posedge clk);
      reset_n <= 1'b0;
      for (a = 0; a < MEM_WORDS; a++) begin
         if (a < PROG_MAX) begin
            imem[a] <= prog[t][a];
         end else begin
            imem[a] <= jump_inst(12'(a));
         end
      end
      @(posedge clk);
      @(negedge clk);
      check_word("o_output_port in reset", '0, output_port);
      check_word("o_num_inst in reset", '0, num_inst);
      check_word("o_is_halted in reset", '0, word_t'(is_halted));
      check_word("o_i_address in reset", '0, i_address);
      repeat (RESET_CYCLES - 1) @(posedge clk);
      reset_n <= 1'b1;
      @(negedge clk);
      check_word("o_output_port after reset", '0, output_port);
      check_word("o_num_inst after reset", '0, num_inst);
      check_word("o_is_halted after reset", '0, word_t'(is_halted));

      // Bounded by the watchdog
      while (!is_halted) @(negedge clk);
      check_word("o_output_port", exp_out[t], output_port);
      check_word("o_num_inst", exp_num[t], num_inst);
      check_word("o_i_address", exp_pc[t], i_address);

      // Halted core stays frozen
      held_out = output_port;
      held_num = num_inst;
      repeat (HALT_HOLD) begin
         @(negedge clk);
         check_word("o_is_halted after halt", 16'd1, word_t'(is_halted));
         check_word("o_output_port after halt", held_out, output_port);
         check_word("o_num_inst after halt", held_num, num_inst);
         check_word("o_i_address after halt", exp_pc[t], i_address);
      end

      if (test_errors == 0) begin
         pass_count++;
         $display("test %s: passed", cur_name);
      end else begin
         $display("test %s: failed with %0d errors", cur_name, test_errors);
      end
   endtask

   initial begin
      int a;
      int t;
      reset_n  = 1'b0;
      cur_name = "startup";
      for (a = 0; a < MEM_WORDS; a++) begin
         imem[a] = jump_inst(12'(a));
      end
      fill_table();
      for (t = 0; t < N_TESTS; t++) begin
         run_test(t);
      end
      $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
               N_TESTS, pass_count, N_TESTS - pass_count, error_count);
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- sim.f
design/cpu_pkg.sv
design/wb_if.sv
design/stage_reg.sv
design/register_file.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/pipeline_control.sv
design/retire_counter.sv
design/cpu_top.sv
sim/cpu_props.sv
sim/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module cpu_tb -o Vcpu_tb
./obj_dir/Vcpu_tb | tee sim.log

if grep -q "Finished with no errors" sim.log; then
   echo "Simulation PASSED"
else
   echo "Simulation FAILED"
   exit 1
fi
